/* source/rv_pkg.sv */
// rv_pkg
// shared types and encodings for the single-cycle RV32I core
// word and register-index types, opcodes, ALU selects, control and retire records

package rv_pkg;

    // data, address and instruction word
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // ALU operation select
    typedef logic [3:0] alu_sel_t;

    localparam alu_sel_t alu_add    = 4'd0;
    localparam alu_sel_t alu_sub    = 4'd1;
    localparam alu_sel_t alu_sll    = 4'd2;
    localparam alu_sel_t alu_slt    = 4'd3;
    localparam alu_sel_t alu_sltu   = 4'd4;
    localparam alu_sel_t alu_xor    = 4'd5;
    localparam alu_sel_t alu_srl    = 4'd6;
    localparam alu_sel_t alu_sra    = 4'd7;
    localparam alu_sel_t alu_or     = 4'd8;
    localparam alu_sel_t alu_and    = 4'd9;
    // lui result is the immediate itself
    localparam alu_sel_t alu_pass_b = 4'd10;

    // base opcodes handled by the core
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // operand a source
    localparam logic a_sel_rs1 = 1'b0;
    localparam logic a_sel_pc  = 1'b1;

    // operand b source
    localparam logic [1:0] b_sel_rs2  = 2'd0;
    localparam logic [1:0] b_sel_imm  = 2'd1;
    localparam logic [1:0] b_sel_four = 2'd2;

    // decode to execute
    typedef struct packed {
        alu_sel_t    alu_sel;
        logic        a_sel;
        logic [1:0]  b_sel;
        word_t       imm;
        reg_idx_t    rd;
        logic        reg_write;
        logic        is_branch;
        logic [2:0]  branch_funct;
        logic        is_jal;
        logic        is_jalr;
    } ctrl_t;

    // one retired instruction
    typedef struct packed {
        word_t       pc;
        reg_idx_t    rd;
        word_t       data;
        logic        reg_write;
    } retire_t;

endpackage

/* source/rv_fetch.sv */
// rv_fetch
// program counter and Wishbone classic instruction fetch
// keeps one read request open and loads the pc on every acknowledge

module rv_fetch #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output rv_pkg::word_t wb_adr,
    input  logic          wb_ack,
    input  rv_pkg::word_t wb_dat_r,
    input  rv_pkg::word_t next_pc,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t instr,
    output logic          fetch_done
);

    // idle only while in reset, request from then on
    typedef enum logic {
        st_idle,
        st_request
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            pc    <= RESET_PC;
        end else begin
            case (state)
                st_idle: begin
                    // first request one cycle after reset drops
                    state <= st_request;
                end
                st_request: begin
                    // instruction retires this cycle, move on
                    if (wb_ack) begin
                        pc <= next_pc;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // request stays up across instructions
    assign wb_cyc = (state == st_request);
    assign wb_stb = (state == st_request);
    // read only port
    assign wb_we  = 1'b0;
    assign wb_adr = pc;

    // instruction word goes straight to decode
    assign instr      = wb_dat_r;
    assign fetch_done = wb_stb & wb_ack;

    // bus rules seen from the master side
    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("wb_stb high outside a bus cycle");

    // address held through wait states
    a_adr_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else $error("wb_adr changed while a request was waiting");

    // next_pc from execute must keep word alignment
    a_pc_align: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

/* source/rv_decode.sv */
// rv_decode
// combinational RV32I decoder
// opcode and funct fields to the control record, immediates for all used formats

module rv_decode (
    input  rv_pkg::word_t    instr,
    output rv_pkg::ctrl_t    ctrl,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2
);

    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    // funct7 bit 30 picks sub and sra
    logic       funct7_b30;
    reg_idx_t   rd;

    word_t imm_i;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // funct3 to ALU select, alt only honoured where the ISA defines it
    function automatic alu_sel_t alu_decode(
        input logic [2:0] f3,
        input logic       alt,
        input logic       reg_form
    );
        case (f3)
            3'b000:  alu_decode = (reg_form && alt) ? alu_sub : alu_add;
            3'b001:  alu_decode = alu_sll;
            3'b010:  alu_decode = alu_slt;
            3'b011:  alu_decode = alu_sltu;
            3'b100:  alu_decode = alu_xor;
            // srai and srli share funct3
            3'b101:  alu_decode = alt ? alu_sra : alu_srl;
            3'b110:  alu_decode = alu_or;
            default: alu_decode = alu_and;
        endcase
    endfunction

    // fixed field positions
    assign opcode     = instr[6:0];
    assign rd         = instr[11:7];
    assign funct3     = instr[14:12];
    assign rs1        = instr[19:15];
    assign rs2        = instr[24:20];
    assign funct7_b30 = instr[30];

    // sign extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // unknown opcodes fall through as a no-op
        ctrl              = '0;
        ctrl.alu_sel      = alu_add;
        ctrl.a_sel        = a_sel_rs1;
        ctrl.b_sel        = b_sel_rs2;
        ctrl.rd           = rd;
        ctrl.branch_funct = funct3;

        case (opcode)
            opc_lui: begin
                ctrl.alu_sel   = alu_pass_b;
                ctrl.b_sel     = b_sel_imm;
                ctrl.imm       = imm_u;
                ctrl.reg_write = 1'b1;
            end
            opc_auipc: begin
                ctrl.a_sel     = a_sel_pc;
                ctrl.b_sel     = b_sel_imm;
                ctrl.imm       = imm_u;
                ctrl.reg_write = 1'b1;
            end
            opc_jal: begin
                // link value pc + 4 through the ALU
                ctrl.a_sel     = a_sel_pc;
                ctrl.b_sel     = b_sel_four;
                ctrl.imm       = imm_j;
                ctrl.reg_write = 1'b1;
                ctrl.is_jal    = 1'b1;
            end
            opc_jalr: begin
                ctrl.a_sel     = a_sel_pc;
                ctrl.b_sel     = b_sel_four;
                ctrl.imm       = imm_i;
                ctrl.reg_write = 1'b1;
                ctrl.is_jalr   = 1'b1;
            end
            opc_branch: begin
                // compare happens in execute on funct3
                ctrl.imm       = imm_b;
                ctrl.is_branch = 1'b1;
            end
            opc_op_imm: begin
                ctrl.alu_sel   = alu_decode(funct3, funct7_b30, 1'b0);
                ctrl.b_sel     = b_sel_imm;
                ctrl.imm       = imm_i;
                ctrl.reg_write = 1'b1;
            end
            opc_op: begin
                ctrl.alu_sel   = alu_decode(funct3, funct7_b30, 1'b1);
                ctrl.reg_write = 1'b1;
            end
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
    end

endmodule

/* source/rv_regfile.sv */
// rv_regfile
// 32-entry integer register file, x0 hardwired to zero
// two combinational read ports, one write port on the clock edge

module rv_regfile (
    input  logic             clk,
    input  rv_pkg::reg_idx_t raddr_a,
    input  rv_pkg::reg_idx_t raddr_b,
    output rv_pkg::word_t    rdata_a,
    output rv_pkg::word_t    rdata_b,
    input  logic             wen,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::word_t    wdata
);

    import rv_pkg::*;

    // x1 .. x31 only, no storage for x0
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        // writes to x0 dropped
        if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // result from execute must be fully known when committed
    a_wdata_known: assert property (@(posedge clk) wen |-> !$isunknown(wdata))
        else $error("register write with unknown data");

endmodule

/* source/rv_execute.sv */
// rv_execute
// combinational execute stage
// operand select, ALU, branch compare, next pc and the retire record

module rv_execute (
    input  rv_pkg::ctrl_t    ctrl,
    input  rv_pkg::word_t    pc,
    input  rv_pkg::word_t    src1,
    input  rv_pkg::word_t    src2,
    input  logic             fetch_done,
    output rv_pkg::word_t    next_pc,
    output logic             reg_wen,
    output rv_pkg::reg_idx_t reg_waddr,
    output rv_pkg::word_t    reg_wdata,
    output logic             retire_valid,
    output rv_pkg::retire_t  retire
);

    import rv_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      alu_result;
    logic [4:0] shamt;
    word_t      pc_plus4;
    word_t      pc_rel;
    word_t      jalr_target;
    logic       taken;

    // operand muxes
    assign op_a = (ctrl.a_sel == a_sel_pc) ? pc : src1;

    always_comb begin
        case (ctrl.b_sel)
            b_sel_imm:  op_b = ctrl.imm;
            b_sel_four: op_b = 32'd4;
            default:    op_b = src2;
        endcase
    end

    // shifts use the low five bits only
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_sel)
            alu_sub:    alu_result = op_a - op_b;
            alu_sll:    alu_result = op_a << shamt;
            alu_slt:    alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_result = {31'd0, op_a < op_b};
            alu_xor:    alu_result = op_a ^ op_b;
            alu_srl:    alu_result = op_a >> shamt;
            alu_sra:    alu_result = $signed(op_a) >>> shamt;
            alu_or:     alu_result = op_a | op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_pass_b: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // branch condition straight from rs1 and rs2
    always_comb begin
        case (ctrl.branch_funct)
            // beq, bne
            3'b000:  taken = (src1 == src2);
            3'b001:  taken = (src1 != src2);
            // blt, bge
            3'b100:  taken = ($signed(src1) < $signed(src2));
            3'b101:  taken = ($signed(src1) >= $signed(src2));
            // bltu, bgeu
            3'b110:  taken = (src1 < src2);
            3'b111:  taken = (src1 >= src2);
            default: taken = 1'b0;
        endcase
    end

    // next pc candidates
    assign pc_plus4    = pc + 32'd4;
    assign pc_rel      = pc + ctrl.imm;
    assign jalr_target = (src1 + ctrl.imm) & ~32'd1;

    always_comb begin
        if (ctrl.is_jalr) begin
            next_pc = jalr_target;
        end else if (ctrl.is_jal || (ctrl.is_branch && taken)) begin
            next_pc = pc_rel;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // write only in the acknowledge cycle
    assign reg_wen   = ctrl.reg_write & fetch_done;
    assign reg_waddr = ctrl.rd;
    assign reg_wdata = alu_result;

    // retire record, data zero when nothing is written
    assign retire_valid     = fetch_done;
    assign retire.pc        = pc;
    assign retire.rd        = ctrl.rd;
    assign retire.data      = ctrl.reg_write ? alu_result : '0;
    assign retire.reg_write = ctrl.reg_write;

    // decode must only hand over defined ALU selects
    always_comb begin
        if (fetch_done) begin
            a_alu_sel_defined: assert (ctrl.alu_sel <= alu_pass_b)
                else $error("undefined ALU select %0d", ctrl.alu_sel);
        end
    end

endmodule

/* source/rv_core.sv */
// rv_core
// single-cycle RV32I integer core with a Wishbone classic instruction port
// one instruction retires per fetch acknowledge

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output rv_pkg::word_t   wb_adr,
    input  logic            wb_ack,
    input  rv_pkg::word_t   wb_dat_r,
    output logic            retire_valid,
    output rv_pkg::retire_t retire
);

    import rv_pkg::*;

    // fetch to decode and execute
    word_t    pc;
    word_t    instr;
    logic     fetch_done;
    // execute back to fetch
    word_t    next_pc;
    // decoded control and register operands
    ctrl_t    ctrl;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    src1;
    word_t    src2;
    // writeback
    logic     reg_wen;
    reg_idx_t reg_waddr;
    word_t    reg_wdata;

    rv_fetch #(
        .RESET_PC   (RESET_PC)
    ) u_fetch (
        .clk        (clk),
        .rst        (rst),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .next_pc    (next_pc),
        .pc         (pc),
        .instr      (instr),
        .fetch_done (fetch_done)
    );

    rv_decode u_decode (
        .instr (instr),
        .ctrl  (ctrl),
        .rs1   (rs1),
        .rs2   (rs2)
    );

    rv_regfile u_regfile (
        .clk     (clk),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .rdata_a (src1),
        .rdata_b (src2),
        .wen     (reg_wen),
        .waddr   (reg_waddr),
        .wdata   (reg_wdata)
    );

    rv_execute u_execute (
        .ctrl         (ctrl),
        .pc           (pc),
        .src1         (src1),
        .src2         (src2),
        .fetch_done   (fetch_done),
        .next_pc      (next_pc),
        .reg_wen      (reg_wen),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

/* verification/rv_tb_program.svh */
// rv_tb_program
// instruction encoders and the program builder for the core testbench
// directed tests first, then a random OP / OP-IMM block ending in a self loop

`ifndef RV_TB_PROGRAM_SVH
`define RV_TB_PROGRAM_SVH

function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                input logic [2:0] f3, input int rd);
    enc_r = {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
endfunction

function automatic word_t enc_i(input logic [6:0] opc, input int imm, input int rs1,
                                input logic [2:0] f3, input int rd);
    enc_i = {12'(imm), 5'(rs1), f3, 5'(rd), opc};
endfunction

function automatic word_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                input int off);
    logic [12:0] o;
    o = 13'(off);
    enc_b = {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011};
endfunction

function automatic word_t enc_u(input logic [6:0] opc, input logic [19:0] imm, input int rd);
    enc_u = {imm, 5'(rd), opc};
endfunction

function automatic word_t enc_j(input int rd, input int off);
    logic [20:0] o;
    o = 21'(off);
    enc_j = {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
endfunction

task automatic emit(input word_t w);
    mem[wp] = w;
    wp++;
endtask

// last emitted word closes a test, it must be one that executes
task automatic close_test(input string name);
    test_name.push_back(name);
    test_end.push_back(word_t'((wp - 1) * 4));
endtask

task automatic build_program();
    // branch funct3 with a taken and a not-taken operand pair each
    logic [2:0] f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    int tk1 [6] = '{3, 3, 1, 3, 3, 1};
    int tk2 [6] = '{3, 1, 3, 1, 1, 3};
    int nt1 [6] = '{3, 3, 3, 1, 1, 3};
    int nt2 [6] = '{1, 3, 1, 3, 3, 1};
    logic [2:0] f3;
    int imm;
    wp = 0;
    // every register gets a known value
    for (int i = 1; i < 32; i++) emit(enc_i(7'h13, i * 37, 0, 3'd0, i));
    close_test("init");
    // x1 most negative, x2 all ones, x3 = 21, x4 near max positive
    emit(enc_u(7'h37, 20'h80000, 1));
    emit(enc_i(7'h13, -1, 0, 3'd0, 2));
    emit(enc_i(7'h13, 21, 0, 3'd0, 3));
    emit(enc_u(7'h37, 20'h7ffff, 4));
    emit(enc_i(7'h13, 2047, 4, 3'd0, 4));
    emit(enc_r(7'h00, 4, 4, 3'd0, 5));
    emit(enc_r(7'h20, 3, 1, 3'd0, 6));
    emit(enc_r(7'h00, 3, 1, 3'd2, 7));
    emit(enc_r(7'h00, 3, 1, 3'd3, 8));
    emit(enc_r(7'h00, 3, 2, 3'd1, 9));
    emit(enc_r(7'h00, 3, 1, 3'd5, 10));
    emit(enc_r(7'h20, 3, 1, 3'd5, 11));
    emit(enc_r(7'h00, 4, 2, 3'd4, 12));
    emit(enc_r(7'h00, 3, 1, 3'd6, 13));
    emit(enc_r(7'h00, 4, 2, 3'd7, 14));
    close_test("alu_reg");
    emit(enc_i(7'h13, -5, 1, 3'd0, 15));
    emit(enc_i(7'h13, -256, 3, 3'd4, 16));
    emit(enc_i(7'h13, -1, 3, 3'd3, 17));
    emit(enc_i(7'h13, -3, 1, 3'd2, 18));
    // srai carries bit 30 in the immediate
    emit(enc_i(7'h13, 32'h400 | 17, 1, 3'd5, 19));
    emit(enc_i(7'h13, 17, 1, 3'd5, 20));
    emit(enc_i(7'h13, 20, 3, 3'd1, 22));
    emit(enc_u(7'h37, 20'habcde, 23));
    emit(enc_u(7'h17, 20'h12345, 24));
    close_test("alu_imm");
    for (int k = 0; k < 6; k++) begin
        emit(enc_b(f3s[k], tk1[k], tk2[k], 8));
        emit(enc_i(7'h13, 1, 21, 3'd0, 21));
        emit(enc_b(f3s[k], nt1[k], nt2[k], 8));
        emit(enc_i(7'h13, 1, 21, 3'd0, 21));
        // backward taken branch, executed once
        emit(enc_j(0, 12));
        emit(enc_i(7'h13, 100, 21, 3'd0, 21));
        emit(enc_j(0, 8));
        emit(enc_b(f3s[k], tk1[k], tk2[k], -8));
    end
    close_test("branch");
    emit(enc_j(25, 8));
    emit(enc_i(7'h13, 1, 0, 3'd0, 26));
    emit(enc_u(7'h17, 20'h0, 24));
    emit(enc_i(7'h13, 13, 24, 3'd0, 24));
    // odd target, bit 0 dropped
    emit(enc_i(7'h67, 4, 24, 3'd0, 26));
    emit(enc_i(7'h13, 2, 0, 3'd0, 27));
    emit(enc_r(7'h00, 26, 25, 3'd0, 27));
    close_test("jump");
    emit(enc_i(7'h13, 55, 0, 3'd0, 0));
    emit(enc_r(7'h00, 2, 1, 3'd0, 0));
    emit(enc_u(7'h37, 20'hfffff, 0));
    emit(enc_r(7'h00, 3, 0, 3'd0, 28));
    emit(enc_j(0, (RAND_BASE - wp) * 4));
    close_test("x0_write");
    wp = RAND_BASE;
    for (int n = 0; n < RAND_COUNT; n++) begin
        rng = xorshift(rng);
        f3 = rng[2:0];
        if (rng[3]) begin
            emit(enc_r({1'b0, rng[4] && (f3 == 0 || f3 == 5), 5'd0}, rng[24:20],
                       rng[19:15], f3, rng[11:7]));
        end else begin
            imm = int'(rng[31:20]);
            if (f3 == 3'd1) imm = imm & 31;
            if (f3 == 3'd5) imm = (imm & 31) | (rng[4] ? 32'h400 : 0);
            emit(enc_i(7'h13, imm, rng[19:15], f3, rng[11:7]));
        end
    end
    close_test("random");
    emit(enc_j(0, 0));
endtask

`endif

/* verification/rv_core_tb.sv */
// rv_core_tb
// drives the core through a Wishbone memory model with random wait states
// every retire is compared with an ISA reference model

module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_pkg::*;

    localparam int MEM_WORDS = 512;
    localparam int MAX_WAIT = 3;
    localparam int RAND_BASE = 256;
    localparam int RAND_COUNT = 200;

    logic clk, rst, wb_cyc, wb_stb, wb_we, wb_ack, retire_valid;
    word_t wb_adr, wb_dat_r, req_adr, model_pc, npc;
    retire_t retire, exp;
    word_t mem [MEM_WORDS];
    word_t model_regs [32];
    int wp, checks, fails, test_idx, test_fails, test_checks;
    logic [31:0] rng = 32'h7c1c;
    string test_name [$];
    word_t test_end [$];

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        xorshift = s ^ (s << 5);
    endfunction

    `include "rv_tb_program.svh"

    rv_core #(.RESET_PC(32'h0)) UUT (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r),
        .retire_valid(retire_valid), .retire(retire)
    );

    // base ISA arithmetic, alt is bit 30 where it applies
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0: alu_ref = alt ? a - b : a + b;
            3'd1: alu_ref = a << b[4:0];
            3'd2: alu_ref = word_t'($signed(a) < $signed(b));
            3'd3: alu_ref = word_t'(a < b);
            3'd4: alu_ref = a ^ b;
            3'd5: alu_ref = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    function automatic retire_t rv_ref_step(input word_t regs [32], input word_t pc,
                                            input word_t ins, output word_t next);
        word_t a, b, imm_i, imm_b, imm_j, res;
        logic [2:0] f3;
        logic cond;
        retire_t r;
        a = regs[ins[19:15]];
        b = regs[ins[24:20]];
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        next = pc + 4;
        res = 0;
        r.reg_write = 1'b1;
        case (ins[6:0])
            7'h37: res = {ins[31:12], 12'h0};
            7'h17: res = pc + {ins[31:12], 12'h0};
            7'h6f: begin
                res = pc + 4;
                next = pc + imm_j;
            end
            7'h67: begin
                res = pc + 4;
                next = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                r.reg_write = 1'b0;
                case (f3)
                    3'd0: cond = a == b;
                    3'd1: cond = a != b;
                    3'd4: cond = $signed(a) < $signed(b);
                    3'd5: cond = $signed(a) >= $signed(b);
                    3'd6: cond = a < b;
                    default: cond = a >= b;
                endcase
                if (cond) next = pc + imm_b;
            end
            7'h13: res = alu_ref(f3, (f3 == 3'd5) && ins[30], a, imm_i);
            7'h33: res = alu_ref(f3, ins[30], a, b);
            default: r.reg_write = 1'b0;
        endcase
        r.pc = pc;
        r.rd = ins[11:7];
        r.data = r.reg_write ? res : '0;
        rv_ref_step = r;
    endfunction

    task automatic count_fail();
        fails++;
        test_fails++;
    endtask

    initial begin
        clk = 0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1;
        model_pc = 0;
        foreach (model_regs[i]) model_regs[i] = 0;
        // unused words are addi x0 no-ops tagged with their index
        foreach (mem[i]) mem[i] = 32'h0000_0013 | (i << 20);
        build_program();
        repeat (16) @(posedge clk);
        #1 rst = 0;
    end

    // memory slave, ack at least one cycle after the request is seen
    initial begin
        wb_ack = 0;
        wb_dat_r = 0;
        wait (rst == 1'b0);
        @(posedge clk);
        #1;
        forever begin
            if (wb_stb) begin
                req_adr = wb_adr;
                rng = xorshift(rng);
                repeat (int'(rng % (MAX_WAIT + 1)) + 1) @(posedge clk);
                #1;
                checks += 2;
                assert (wb_adr == req_adr && req_adr == model_pc) else begin
                    $display("fetch address deviates from the model pc at %h", model_pc);
                    count_fail();
                end
                // read cycle held open until the acknowledge
                assert (wb_cyc && wb_stb && !wb_we) else begin
                    $display("fetch request not held as an open read cycle at %h", req_adr);
                    count_fail();
                end
                wb_ack = 1;
                wb_dat_r = mem[wb_adr[10:2]];
                @(posedge clk);
                #1 wb_ack = 0;
            end else begin
                @(posedge clk);
                #1;
            end
        end
    end

    // compare process, one record per acknowledge
    always @(posedge clk) begin
        if (!rst && retire_valid) begin
            exp = rv_ref_step(model_regs, model_pc, mem[model_pc[10:2]], npc);
            checks += 4;
            test_checks += 4;
            assert (retire.pc == exp.pc) else begin
                $display("mismatch retire.pc exp %h got %h", exp.pc, retire.pc);
                count_fail();
            end
            assert (retire.reg_write == exp.reg_write) else begin
                $display("mismatch retire.reg_write exp %h got %h at pc %h",
                         exp.reg_write, retire.reg_write, exp.pc);
                count_fail();
            end
            // rd only means something when a register is written
            assert (!exp.reg_write || retire.rd == exp.rd) else begin
                $display("mismatch retire.rd exp %h got %h at pc %h", exp.rd, retire.rd, exp.pc);
                count_fail();
            end
            assert (retire.data == exp.data) else begin
                $display("mismatch retire.data exp %h got %h at pc %h",
                         exp.data, retire.data, exp.pc);
                count_fail();
            end
            if (exp.reg_write && exp.rd != 0) model_regs[exp.rd] = exp.data;
            model_pc = npc;
            if (test_idx < test_name.size() && exp.pc == test_end[test_idx]) begin
                $display("test %s: %0d checks, %0d errors", test_name[test_idx],
                         test_checks, test_fails);
                test_idx++;
                test_checks = 0;
                test_fails = 0;
            end
            // self loop reached
            if (npc == exp.pc) begin
                $display("checks passed %0d failed %0d", checks - fails, fails);
                if (fails == 0) begin
                    $display("Testbench passed");
                end else begin
                    $display("Testbench failed");
                end
                $finish;
            end
        end
    end

    // watchdog sized from the program length
    initial begin
        #1;
        repeat (16 + wp * (MAX_WAIT + 2) + 100) @(posedge clk);
        $display("core stopped retiring before the end of the program");
        $display("Testbench failed");
        $finish;
    end

endmodule

/* rv_core.f */
+incdir+verification
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_core.sv
verification/rv_core_tb.sv

/* run_sim.sh */
#!/bin/bash
# builds the core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f rv_core.f --top-module rv_core_tb -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vrv_core_tb > sim.log 2>&1 \
    || echo "build or simulation stopped with an error"

cat sim.log 2>/dev/null || cat build.log

if [ ! -f sim.log ] || grep -q "Testbench failed" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
